// ==== verilog/mem_sys_pkg.sv ====
package mem_sys_pkg;

    // address and line geometry
    localparam int XLEN        = 32;
    localparam int LINE_BITS   = 128;
    localparam int OFFSET_BITS = 4;
    localparam int INDEX_BITS  = 6;
    localparam int TAG_BITS    = XLEN - INDEX_BITS - OFFSET_BITS;
    localparam int NUM_LINES   = 1 << INDEX_BITS;

    // store width, same coding as the core's mem_width
    typedef enum logic [1:0] {
        WIDTH_BYTE = 2'd0,
        WIDTH_HALF = 2'd1,
        WIDTH_WORD = 2'd2
    } width_e;

    // line bus, shared by both caches
    typedef struct packed {
        logic                 req;
        logic                 we;
        logic [XLEN-1:0]      addr;
        logic [LINE_BITS-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic                 ready;
        logic [LINE_BITS-1:0] rdata;
    } bus_rsp_t;

    // load or store from the requester
    typedef struct packed {
        logic            valid;
        logic            rw;
        logic [XLEN-1:0] addr;
        width_e          width;
        logic [XLEN-1:0] wdata;
    } dreq_t;

    typedef struct packed {
        logic [LINE_BITS-1:0] data;
    } ientry_t;

    typedef struct packed {
        logic                 dirty;
        logic [LINE_BITS-1:0] data;
    } dentry_t;

endpackage

// ==== verilog/cache_line_array.sv ====
`timescale 1ns/1ns

module cache_line_array
    import mem_sys_pkg::*;
#(
    parameter type entry_t = ientry_t
) (
    input  logic                  clk,
    input  logic                  rst_n_i,

    input  logic [INDEX_BITS-1:0] rd_index_i,
    output logic                  rd_valid_o,
    output logic [TAG_BITS-1:0]   rd_tag_o,
    output entry_t                rd_entry_o,

    input  logic                  wr_en_i,
    input  logic [INDEX_BITS-1:0] wr_index_i,
    input  logic [TAG_BITS-1:0]   wr_tag_i,
    input  entry_t                wr_entry_i
);

    logic [NUM_LINES-1:0] valid_q;
    logic [TAG_BITS-1:0]  tag_q   [NUM_LINES];
    entry_t               entry_q [NUM_LINES];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (wr_en_i) begin
            valid_q[wr_index_i] <= 1'b1;
        end
    end

    // tag and payload only mean something once valid is set
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_q[wr_index_i]   <= wr_tag_i;
            entry_q[wr_index_i] <= wr_entry_i;
        end
    end

    assign rd_valid_o = valid_q[rd_index_i];
    assign rd_tag_o   = tag_q[rd_index_i];
    assign rd_entry_o = entry_q[rd_index_i];

endmodule

// ==== verilog/icache.sv ====
`timescale 1ns/1ns

module icache
    import mem_sys_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,

    input  logic            fetch_req_i,
    input  logic [XLEN-1:0] fetch_addr_i,
    output logic            fetch_ready_o,
    output logic [XLEN-1:0] fetch_inst_o,

    output bus_req_t        bus_req_o,
    input  bus_rsp_t        bus_rsp_i
);

    typedef enum logic [1:0] {
        S_LOOKUP,
        S_REFILL,
        S_RESPOND
    } state_e;

    state_e                state_q;
    state_e                state_d;
    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    logic                  rd_valid;
    logic [TAG_BITS-1:0]   rd_tag;
    ientry_t               rd_entry;
    ientry_t               wr_entry;
    logic                  hit;
    logic                  refill_done;
    logic [XLEN-1:0]       inst_q;

    assign index       = fetch_addr_i[OFFSET_BITS +: INDEX_BITS];
    assign tag         = fetch_addr_i[XLEN-1 -: TAG_BITS];
    assign hit         = rd_valid && (rd_tag == tag);
    assign refill_done = (state_q == S_REFILL) && bus_rsp_i.ready;
    assign wr_entry    = '{data: bus_rsp_i.rdata};

    cache_line_array #(
        .entry_t(ientry_t)
    ) lines_ins (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .rd_index_i(index),
        .rd_valid_o(rd_valid),
        .rd_tag_o(rd_tag),
        .rd_entry_o(rd_entry),
        .wr_en_i(refill_done),
        .wr_index_i(index),
        .wr_tag_i(tag),
        .wr_entry_i(wr_entry)
    );

    // after a refill the lookup runs again and hits on the new line
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_LOOKUP:  if (fetch_req_i) state_d = hit ? S_RESPOND : S_REFILL;
            S_REFILL:  if (bus_rsp_i.ready) state_d = S_LOOKUP;
            default:   state_d = S_LOOKUP;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_LOOKUP && fetch_req_i && hit) begin
            inst_q <= rd_entry.data[fetch_addr_i[OFFSET_BITS-1:2]*XLEN +: XLEN];
        end
    end

    assign fetch_ready_o = (state_q == S_RESPOND);
    assign fetch_inst_o  = inst_q;

    // read-only, so the bus only ever sees line reads
    assign bus_req_o.req   = (state_q == S_REFILL);
    assign bus_req_o.we    = 1'b0;
    assign bus_req_o.addr  = {tag, index, {OFFSET_BITS{1'b0}}};
    assign bus_req_o.wdata = '0;

    a_fetch_addr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        fetch_req_i && !fetch_ready_o |=> fetch_req_i && $stable(fetch_addr_i));

endmodule

// ==== verilog/dcache.sv ====
`timescale 1ns/1ns

module dcache
    import mem_sys_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,

    input  dreq_t           dreq_i,
    output logic            dready_o,
    output logic [XLEN-1:0] drdata_o,

    output bus_req_t        bus_req_o,
    input  bus_rsp_t        bus_rsp_i
);

    typedef enum logic [1:0] {
        S_LOOKUP,
        S_WRITEBACK,
        S_REFILL,
        S_RESPOND
    } state_e;

    state_e                state_q;
    state_e                state_d;
    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    logic [1:0]            word_sel;
    logic                  rd_valid;
    logic [TAG_BITS-1:0]   rd_tag;
    dentry_t               rd_entry;
    dentry_t               wr_entry;
    logic                  wr_en;
    logic                  hit;
    logic [XLEN-1:0]       old_word;
    logic [XLEN-1:0]       store_word;
    logic [XLEN-1:0]       merged_word;
    logic [3:0]            byte_en;
    logic [LINE_BITS-1:0]  store_line;
    logic [XLEN-1:0]       rdata_q;

    assign index    = dreq_i.addr[OFFSET_BITS +: INDEX_BITS];
    assign tag      = dreq_i.addr[XLEN-1 -: TAG_BITS];
    assign word_sel = dreq_i.addr[OFFSET_BITS-1:2];
    assign hit      = rd_valid && (rd_tag == tag);
    assign old_word = rd_entry.data[word_sel*XLEN +: XLEN];

    cache_line_array #(
        .entry_t(dentry_t)
    ) lines_ins (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .rd_index_i(index),
        .rd_valid_o(rd_valid),
        .rd_tag_o(rd_tag),
        .rd_entry_o(rd_entry),
        .wr_en_i(wr_en),
        .wr_index_i(index),
        .wr_tag_i(tag),
        .wr_entry_i(wr_entry)
    );

    // byte lanes from width and the low address bits
    always_comb begin
        case (dreq_i.width)
            WIDTH_BYTE: begin
                byte_en    = 4'b0001 << dreq_i.addr[1:0];
                store_word = {4{dreq_i.wdata[7:0]}};
            end
            WIDTH_HALF: begin
                byte_en    = 4'b0011 << dreq_i.addr[1:0];
                store_word = {2{dreq_i.wdata[15:0]}};
            end
            default: begin
                byte_en    = 4'b1111;
                store_word = dreq_i.wdata;
            end
        endcase
        for (int b = 0; b < 4; b++) begin
            merged_word[b*8 +: 8] = byte_en[b] ? store_word[b*8 +: 8] : old_word[b*8 +: 8];
        end
        store_line = rd_entry.data;
        store_line[word_sel*XLEN +: XLEN] = merged_word;
    end

    // refill lands clean, a store hit marks the line dirty
    always_comb begin
        if (state_q == S_REFILL) begin
            wr_entry = '{dirty: 1'b0, data: bus_rsp_i.rdata};
        end else begin
            wr_entry = '{dirty: 1'b1, data: store_line};
        end
    end

    assign wr_en = (state_q == S_LOOKUP && dreq_i.valid && dreq_i.rw && hit) ||
                   (state_q == S_REFILL && bus_rsp_i.ready);

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_LOOKUP: begin
                if (dreq_i.valid) begin
                    if (hit) begin
                        state_d = S_RESPOND;
                    end else if (rd_valid && rd_entry.dirty) begin
                        state_d = S_WRITEBACK;
                    end else begin
                        state_d = S_REFILL;
                    end
                end
            end
            S_WRITEBACK: if (bus_rsp_i.ready) state_d = S_REFILL;
            S_REFILL:    if (bus_rsp_i.ready) state_d = S_LOOKUP;
            default:     state_d = S_LOOKUP;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_LOOKUP && dreq_i.valid && hit) begin
            rdata_q <= old_word;
        end
    end

    assign dready_o = (state_q == S_RESPOND);
    assign drdata_o = rdata_q;

    // victim goes back under its own tag
    assign bus_req_o.req   = (state_q == S_WRITEBACK) || (state_q == S_REFILL);
    assign bus_req_o.we    = (state_q == S_WRITEBACK);
    assign bus_req_o.addr  = (state_q == S_WRITEBACK) ?
                             {rd_tag, index, {OFFSET_BITS{1'b0}}} :
                             {tag, index, {OFFSET_BITS{1'b0}}};
    assign bus_req_o.wdata = rd_entry.data;

    a_width_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
        dreq_i.valid |-> dreq_i.width inside {WIDTH_BYTE, WIDTH_HALF, WIDTH_WORD});

    a_half_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        dreq_i.valid && dreq_i.rw && dreq_i.width == WIDTH_HALF |-> !dreq_i.addr[0]);

    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        dreq_i.valid && dreq_i.rw && dreq_i.width == WIDTH_WORD |-> dreq_i.addr[1:0] == 2'b00);

endmodule

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/1ns

module mem_arbiter
    import mem_sys_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n_i,

    input  bus_req_t icache_req_i,
    output bus_rsp_t icache_rsp_o,
    input  bus_req_t dcache_req_i,
    output bus_rsp_t dcache_rsp_o,

    output bus_req_t mem_req_o,
    input  bus_rsp_t mem_rsp_i
);

    // one-hot owner, bit 1 is the data side
    logic [1:0] grant_q;
    logic [1:0] grant;

    // data side wins a fresh grant, the core stalls on its misses
    always_comb begin
        if (grant_q != 2'b00) begin
            grant = grant_q;
        end else if (dcache_req_i.req) begin
            grant = 2'b10;
        end else if (icache_req_i.req) begin
            grant = 2'b01;
        end else begin
            grant = 2'b00;
        end
    end

    assign mem_req_o = grant[1] ? dcache_req_i : icache_req_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            grant_q <= 2'b00;
        end else if (mem_rsp_i.ready) begin
            grant_q <= 2'b00;
        end else if (mem_req_o.req) begin
            grant_q <= grant;
        end
    end

    // ready only to the owner, data fans out to both
    assign icache_rsp_o.ready = mem_rsp_i.ready && grant[0];
    assign icache_rsp_o.rdata = mem_rsp_i.rdata;
    assign dcache_rsp_o.ready = mem_rsp_i.ready && grant[1];
    assign dcache_rsp_o.rdata = mem_rsp_i.rdata;

    a_one_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(icache_rsp_o.ready && dcache_rsp_o.ready));

    // the owning cache keeps its request up until served
    a_grant_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        grant_q != 2'b00 |-> mem_req_o.req);

endmodule

// ==== verilog/rv32_mem_sys.sv ====
`timescale 1ns/1ns

module rv32_mem_sys
    import mem_sys_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,

    // instruction side
    input  logic            fetch_req_i,
    input  logic [XLEN-1:0] fetch_addr_i,
    output logic            fetch_ready_o,
    output logic [XLEN-1:0] fetch_inst_o,

    // data side
    input  dreq_t           dreq_i,
    output logic            dready_o,
    output logic [XLEN-1:0] drdata_o,

    // external line bus
    output bus_req_t        mem_req_o,
    input  bus_rsp_t        mem_rsp_i
);

    bus_req_t icache_bus_req;
    bus_rsp_t icache_bus_rsp;
    bus_req_t dcache_bus_req;
    bus_rsp_t dcache_bus_rsp;

    icache icache_ins (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .fetch_req_i(fetch_req_i),
        .fetch_addr_i(fetch_addr_i),
        .fetch_ready_o(fetch_ready_o),
        .fetch_inst_o(fetch_inst_o),
        .bus_req_o(icache_bus_req),
        .bus_rsp_i(icache_bus_rsp)
    );

    dcache dcache_ins (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .dreq_i(dreq_i),
        .dready_o(dready_o),
        .drdata_o(drdata_o),
        .bus_req_o(dcache_bus_req),
        .bus_rsp_i(dcache_bus_rsp)
    );

    mem_arbiter arbiter_ins (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .icache_req_i(icache_bus_req),
        .icache_rsp_o(icache_bus_rsp),
        .dcache_req_i(dcache_bus_req),
        .dcache_rsp_o(dcache_bus_rsp),
        .mem_req_o(mem_req_o),
        .mem_rsp_i(mem_rsp_i)
    );

endmodule

// ==== sim/tb_mem_model.sv ====
`timescale 1ns/1ns

module tb_mem_model
    import mem_sys_pkg::*;
#(
    parameter int WORDS = 4096,
    parameter int SEED  = 0
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  bus_req_t mem_req_i,
    output bus_rsp_t mem_rsp_o
);

    localparam int AW          = $clog2(WORDS);
    localparam int MAX_LATENCY = 6;

    logic [XLEN-1:0] mem [WORDS];
    logic            busy_q;
    logic [2:0]      wait_q;
    logic [XLEN-1:0] addr_q;

    // scrambled so that neighbouring words never match
    function automatic logic [XLEN-1:0] fill_word(input logic [XLEN-1:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [LINE_BITS-1:0] read_line(input logic [XLEN-1:0] addr);
        logic [LINE_BITS-1:0] line;
        for (int w = 0; w < 4; w++) begin
            line[w*XLEN +: XLEN] = mem[{addr[AW+1:4], 2'(w)}];
        end
        return line;
    endfunction

    // backdoor, no bus traffic
    task automatic peek_word(input logic [XLEN-1:0] addr, output logic [XLEN-1:0] data);
        data = mem[addr[AW+1:2]];
    endtask

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = fill_word(XLEN'(i) << 2);
        end
        void'($urandom(SEED));
        forever begin
            @(posedge clk or negedge rst_n_i);
            if (!rst_n_i) begin
                busy_q    <= 1'b0;
                wait_q    <= '0;
                addr_q    <= '0;
                mem_rsp_o <= '0;
            end else if (mem_rsp_o.ready) begin
                // served request is still up for this edge
                mem_rsp_o.ready <= 1'b0;
            end else if (busy_q) begin
                if (wait_q == 3'd1) begin
                    busy_q          <= 1'b0;
                    mem_rsp_o.ready <= 1'b1;
                    mem_rsp_o.rdata <= read_line(addr_q);
                end else begin
                    wait_q <= wait_q - 3'd1;
                end
            end else if (mem_req_i.req) begin
                busy_q <= 1'b1;
                wait_q <= 3'($urandom % MAX_LATENCY + 1);
                addr_q <= mem_req_i.addr;
                if (mem_req_i.we) begin
                    for (int w = 0; w < 4; w++) begin
                        mem[{mem_req_i.addr[AW+1:4], 2'(w)}] = mem_req_i.wdata[w*XLEN +: XLEN];
                    end
                end
            end
        end
    end

endmodule

// ==== sim/tb_rv32_mem_sys.sv ====
`timescale 1ns/1ns

module tb_rv32_mem_sys
    import mem_sys_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS    = 5;
    localparam int TEST_CYCLES  = 200;
    localparam int MAX_WAIT     = 100;
    localparam int SEED         = 22;

    localparam logic [XLEN-1:0] EVICT_A   = 32'h0000_0334;
    localparam logic [XLEN-1:0] EVICT_B   = 32'h0000_0734;
    localparam logic [XLEN-1:0] PAR_FETCH = 32'h0000_0480;
    localparam logic [XLEN-1:0] PAR_LOAD  = 32'h0000_0a90;

    logic            clk;
    logic            rst_n;
    logic            fetch_req;
    logic [XLEN-1:0] fetch_addr;
    logic            fetch_ready;
    logic [XLEN-1:0] fetch_inst;
    dreq_t           dreq;
    logic            dready;
    logic [XLEN-1:0] drdata;
    bus_req_t        mem_req;
    bus_rsp_t        mem_rsp;

    int              errors;
    int              checks;
    int              bus_writes;
    logic [XLEN-1:0] last_write_addr;
    logic            pend;
    logic            pend_we;
    logic [XLEN-1:0] pend_addr;

    rv32_mem_sys uut (
        .clk(clk),
        .rst_n_i(rst_n),
        .fetch_req_i(fetch_req),
        .fetch_addr_i(fetch_addr),
        .fetch_ready_o(fetch_ready),
        .fetch_inst_o(fetch_inst),
        .dreq_i(dreq),
        .dready_o(dready),
        .drdata_o(drdata),
        .mem_req_o(mem_req),
        .mem_rsp_i(mem_rsp)
    );

    tb_mem_model #(
        .SEED(SEED)
    ) memory (
        .clk(clk),
        .rst_n_i(rst_n),
        .mem_req_i(mem_req),
        .mem_rsp_o(mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((RESET_CYCLES + NUM_TESTS * TEST_CYCLES) * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    // one bus transaction at a time, request held until its ready
    always @(negedge clk) begin
        if (!rst_n) begin
            pend = 1'b0;
        end else if (pend) begin
            if (!mem_req.req || mem_req.addr != pend_addr || mem_req.we != pend_we) begin
                errors++;
                $display("bus request changed before ready at %0t", $time);
            end
            if (mem_rsp.ready) begin
                pend = 1'b0;
            end
        end else if (mem_req.req) begin
            pend      = 1'b1;
            pend_we   = mem_req.we;
            pend_addr = mem_req.addr;
            if (mem_req.we) begin
                bus_writes++;
                last_write_addr = mem_req.addr;
            end
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // expected word after a store, from the lane rule
    function automatic logic [XLEN-1:0] merge_store(input logic [XLEN-1:0] old,
                                                    input logic [1:0] off,
                                                    input width_e width,
                                                    input logic [XLEN-1:0] data);
        logic [XLEN-1:0] word;
        word = old;
        case (width)
            WIDTH_BYTE: word[off*8 +: 8] = data[7:0];
            WIDTH_HALF: word[off*8 +: 16] = data[15:0];
            default:    word = data;
        endcase
        return word;
    endfunction

    task automatic fetch_word(input logic [XLEN-1:0] addr, output logic [XLEN-1:0] inst,
                              output int cycles);
        @(posedge clk);
        #DRIVE_DELAY;
        fetch_req  = 1'b1;
        fetch_addr = addr;
        cycles     = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!fetch_ready && cycles < MAX_WAIT);
        if (!fetch_ready) begin
            errors++;
            $display("fetch of %h saw no fetch_ready_o within %0d cycles", addr, MAX_WAIT);
        end
        inst = fetch_inst;
        @(posedge clk);
        #DRIVE_DELAY;
        fetch_req = 1'b0;
    endtask

    task automatic data_access(input logic rw, input logic [XLEN-1:0] addr,
                               input width_e width, input logic [XLEN-1:0] wdata,
                               output logic [XLEN-1:0] rdata);
        int cycles;
        @(posedge clk);
        #DRIVE_DELAY;
        dreq   = '{valid: 1'b1, rw: rw, addr: addr, width: width, wdata: wdata};
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!dready && cycles < MAX_WAIT);
        if (!dready) begin
            errors++;
            $display("access at %h saw no dready_o within %0d cycles", addr, MAX_WAIT);
        end
        rdata = drdata;
        @(posedge clk);
        #DRIVE_DELAY;
        dreq.valid = 1'b0;
    endtask

    task automatic store(input logic [XLEN-1:0] addr, input width_e width,
                         input logic [XLEN-1:0] data);
        logic [XLEN-1:0] unused;
        data_access(1'b1, addr, width, data, unused);
    endtask

    task automatic load(input logic [XLEN-1:0] addr, output logic [XLEN-1:0] data);
        data_access(1'b0, addr, WIDTH_WORD, '0, data);
    endtask

    task automatic after_reset_outputs();
        @(negedge clk);
        check("fetch_ready_o", 32'(fetch_ready), 32'd0);
        check("dready_o", 32'(dready), 32'd0);
        check("mem_req_o.req", 32'(mem_req.req), 32'd0);
    endtask

    task automatic fetch_miss_then_hit();
        logic [XLEN-1:0] exp;
        logic [XLEN-1:0] inst;
        int              cycles;
        memory.peek_word(32'h0000_0104, exp);
        fetch_word(32'h0000_0104, inst, cycles);
        check("fetch_inst_o", inst, exp);
        memory.peek_word(32'h0000_010c, exp);
        fetch_word(32'h0000_010c, inst, cycles);
        check("fetch_inst_o", inst, exp);
        // hit: ready on the second negedge after driving
        check("fetch_ready_o latency", cycles, 32'd2);
    endtask

    task automatic store_lanes_merge();
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] exp;
        logic [XLEN-1:0] got;
        base = 32'h0000_0208;
        memory.peek_word(base, exp);
        store(base + 3, WIDTH_BYTE, 32'h7777_77ab);
        exp = merge_store(exp, 2'd3, WIDTH_BYTE, 32'h7777_77ab);
        store(base, WIDTH_HALF, 32'h8888_1357);
        exp = merge_store(exp, 2'd0, WIDTH_HALF, 32'h8888_1357);
        load(base, got);
        check("drdata_o", got, exp);
        store(base, WIDTH_WORD, 32'h2468_ace0);
        exp = merge_store(exp, 2'd0, WIDTH_WORD, 32'h2468_ace0);
        store(base + 1, WIDTH_BYTE, 32'h0000_005c);
        exp = merge_store(exp, 2'd1, WIDTH_BYTE, 32'h0000_005c);
        store(base + 2, WIDTH_HALF, 32'hffff_9f31);
        exp = merge_store(exp, 2'd2, WIDTH_HALF, 32'hffff_9f31);
        load(base, got);
        check("drdata_o", got, exp);
    endtask

    task automatic dirty_eviction();
        logic [XLEN-1:0] a_line [4];
        logic [XLEN-1:0] b_exp;
        logic [XLEN-1:0] got;
        int              writes;
        for (int w = 0; w < 4; w++) begin
            memory.peek_word({EVICT_A[31:4], 2'(w), 2'b00}, a_line[w]);
        end
        memory.peek_word(EVICT_B, b_exp);
        a_line[EVICT_A[3:2]] = 32'hdead_beef;
        writes = bus_writes;
        store(EVICT_A, WIDTH_WORD, 32'hdead_beef);
        load(EVICT_B, got);
        check("drdata_o", got, b_exp);
        check("write-back count", bus_writes - writes, 32'd1);
        check("write-back mem_req_o.addr", last_write_addr, {EVICT_A[31:4], 4'h0});
        for (int w = 0; w < 4; w++) begin
            memory.peek_word({EVICT_A[31:4], 2'(w), 2'b00}, got);
            check("evicted line word", got, a_line[w]);
        end
    endtask

    task automatic parallel_misses();
        logic [XLEN-1:0] inst_exp;
        logic [XLEN-1:0] data_exp;
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] data;
        int              cycles;
        memory.peek_word(PAR_FETCH, inst_exp);
        memory.peek_word(PAR_LOAD, data_exp);
        fork
            fetch_word(PAR_FETCH, inst, cycles);
            load(PAR_LOAD, data);
        join
        check("fetch_inst_o", inst, inst_exp);
        check("drdata_o", data, data_exp);
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        bus_writes = 0;
        pend       = 1'b0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        dreq       = '{valid: 1'b0, rw: 1'b0, addr: '0, width: WIDTH_WORD, wdata: '0};
        rst_n      = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        after_reset_outputs();
        fetch_miss_then_hit();
        store_lanes_merge();
        dirty_eviction();
        parallel_misses();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
verilog/mem_sys_pkg.sv
verilog/cache_line_array.sv
verilog/icache.sv
verilog/dcache.sv
verilog/mem_arbiter.sv
verilog/rv32_mem_sys.sv
sim/tb_mem_model.sv
sim/tb_rv32_mem_sys.sv

// ==== Makefile ====
# Verilator build and run of the cache memory system

VERILATOR ?= verilator
TOP       ?= tb_rv32_mem_sys
FILELIST  ?= project.f
BUILD     ?= obj_dir
LOG       ?= sim.log
PASS_LINE ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing --assert -j 0

BIN     := $(BUILD)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv sim/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD LOG PASS_LINE VFLAGS"

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

test: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_LINE)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
